/* Bender.yml */
package:
  name: ahb_mem

sources:
  - include_dirs:
      - source
    files:
      - source/ahb_mem_pkg.sv
      - source/ahb_slave.sv
      - source/mem_backend.sv
      - source/ahb_mem_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_ahb_mem.sv

/* files.f */
+incdir+source
source/ahb_mem_pkg.sv
source/ahb_slave.sv
source/mem_backend.sv
source/ahb_mem_top.sv
tb/tb_clk_gen.sv
tb/tb_ahb_mem.sv

/* source/ahb_mem_consts.svh */
`ifndef AHB_MEM_CONSTS_SVH
`define AHB_MEM_CONSTS_SVH

// Bus widths
`define AHB_DATA_W 32
`define AHB_ADDR_W 32

// Storage depth in 32-bit words, 256 words give byte range 0..0x3FF
`define MEM_WORDS 256

// Extra cycles the storage takes per access
`define MEM_WAIT 2

`endif

/* source/ahb_mem_pkg.sv */
`default_nettype none
`include "ahb_mem_consts.svh"

package ahb_mem_pkg;

    localparam int MEM_AW = $clog2(`MEM_WORDS); // Word index width

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    // Front end states
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_DATA = 2'b01,
        ST_ERR1 = 2'b10,
        ST_ERR2 = 2'b11
    } slv_state_e;

    typedef struct packed {
        logic                     valid;
        logic                     we;
        logic [MEM_AW-1:0]        addr;
        logic [`AHB_DATA_W-1:0]   wdata;
        logic [`AHB_DATA_W/8-1:0] wstrb;
    } mem_req_t;

    typedef struct packed {
        logic                   ready;    // One cycle per completed access
        logic                   rd_valid;
        logic [`AHB_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* source/ahb_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ahb_mem_consts.svh"

module ahb_mem_top (
    input  wire                         i_clk_ahb,
    input  wire                         i_rstn_ahb,

    input  wire                         i_hsel,
    input  wire ahb_mem_pkg::htrans_e   i_htrans,
    input  wire ahb_mem_pkg::hsize_e    i_hsize,
    input  wire                         i_hwrite,
    input  wire [`AHB_ADDR_W-1:0]       i_haddr,
    input  wire [`AHB_DATA_W-1:0]       i_hwdata,
    input  wire                         i_hready,

    output logic                        o_hreadyout,
    output logic                        o_hresp,
    output logic [`AHB_DATA_W-1:0]      o_hrdata
);
    import ahb_mem_pkg::*;

    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    ahb_slave slave_i (
        .i_clk_ahb   (i_clk_ahb),
        .i_rstn_ahb  (i_rstn_ahb),
        .i_hsel      (i_hsel),
        .i_htrans    (i_htrans),
        .i_hsize     (i_hsize),
        .i_hwrite    (i_hwrite),
        .i_haddr     (i_haddr),
        .i_hwdata    (i_hwdata),
        .i_hready    (i_hready),
        .o_hreadyout (o_hreadyout),
        .o_hresp     (o_hresp),
        .o_hrdata    (o_hrdata),
        .o_req       (mem_req),
        .i_rsp       (mem_rsp)
    );

    mem_backend backend_i (
        .i_clk_ahb  (i_clk_ahb),
        .i_rstn_ahb (i_rstn_ahb),
        .i_req      (mem_req),
        .o_rsp      (mem_rsp)
    );

endmodule

`default_nettype wire

/* source/ahb_slave.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ahb_mem_consts.svh"

module ahb_slave (
    input  wire                         i_clk_ahb,
    input  wire                         i_rstn_ahb,

    input  wire                         i_hsel,
    input  wire ahb_mem_pkg::htrans_e   i_htrans,
    input  wire ahb_mem_pkg::hsize_e    i_hsize,
    input  wire                         i_hwrite,
    input  wire [`AHB_ADDR_W-1:0]       i_haddr,
    input  wire [`AHB_DATA_W-1:0]       i_hwdata,
    input  wire                         i_hready,

    output logic                        o_hreadyout,
    output logic                        o_hresp,
    output logic [`AHB_DATA_W-1:0]      o_hrdata,

    output ahb_mem_pkg::mem_req_t       o_req,
    input  wire ahb_mem_pkg::mem_rsp_t  i_rsp
);
    import ahb_mem_pkg::*;

    localparam int MEM_BYTES = `MEM_WORDS * 4;

    slv_state_e               state;
    slv_state_e               state_nxt;
    logic                     accept;
    logic                     take;
    logic                     in_range;
    logic [MEM_AW+1:0]        addr_q;    // Byte address inside memory
    logic                     write_q;
    hsize_e                   size_q;
    logic [`AHB_DATA_W/8-1:0] strb;

    // Valid address phase on the bus
    assign accept = i_hsel && i_hready &&
                    (i_htrans == HTRANS_NONSEQ || i_htrans == HTRANS_SEQ);

    // Only taken when our own data phase (if any) is completing
    assign take = accept && o_hreadyout;

    assign in_range = (i_haddr < `AHB_ADDR_W'(MEM_BYTES));

    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_ERR1: state_nxt = ST_ERR2;
            default: begin
                if (take) begin
                    state_nxt = in_range ? ST_DATA : ST_ERR1;
                end else if (o_hreadyout) begin
                    state_nxt = ST_IDLE; // Also ends a finished data phase
                end
            end
        endcase
    end

    // Address phase capture
    always_ff @(posedge i_clk_ahb) begin
        if (take) begin
            addr_q  <= i_haddr[MEM_AW+1:0];
            write_q <= i_hwrite;
            size_q  <= i_hsize;
        end
    end

    always_comb begin
        o_hreadyout = 1'b1;
        o_hresp     = 1'b0;
        case (state)
            ST_DATA: o_hreadyout = i_rsp.ready; // Stall until storage is done
            ST_ERR1: begin
                o_hresp     = 1'b1;
                o_hreadyout = 1'b0;
            end
            ST_ERR2: o_hresp = 1'b1;
            default: o_hreadyout = 1'b1;
        endcase
    end

    // Lane select from size and low address bits
    always_comb begin
        case (size_q)
            HSIZE_BYTE: strb = 4'b0001 << addr_q[1:0];
            HSIZE_HALF: strb = 4'b0011 << {addr_q[1], 1'b0};
            default:    strb = 4'b1111;
        endcase
    end

    always_comb begin
        o_req.valid = (state == ST_DATA);
        o_req.we    = write_q;
        o_req.addr  = addr_q[MEM_AW+1:2];
        o_req.wdata = write_q ? i_hwdata : '0; // Write data arrives in data phase
        o_req.wstrb = write_q ? strb : '0;
    end

    assign o_hrdata = (state == ST_DATA && i_rsp.rd_valid) ? i_rsp.rdata : '0;

    a_resp_only_in_err: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (state == ST_IDLE || state == ST_DATA) |-> !o_hresp
    );

    // Storage sees a steady request while it is stalling the bus
    a_req_stable: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (o_req.valid && !i_rsp.ready) |=> $stable(o_req)
    );

endmodule

`default_nettype wire

/* source/mem_backend.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ahb_mem_consts.svh"

module mem_backend (
    input  wire                         i_clk_ahb,
    input  wire                         i_rstn_ahb,

    input  wire ahb_mem_pkg::mem_req_t  i_req,
    output ahb_mem_pkg::mem_rsp_t       o_rsp
);

    localparam int CNT_W = (`MEM_WAIT > 0) ? $clog2(`MEM_WAIT + 1) : 1;

    logic [`AHB_DATA_W-1:0] mem [`MEM_WORDS];
    logic [CNT_W-1:0]       wait_cnt;
    logic                   done;

    // Access completes after MEM_WAIT cycles of valid
    assign done = i_req.valid && (wait_cnt == CNT_W'(`MEM_WAIT));

    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            wait_cnt <= '0;
        end else if (done) begin
            wait_cnt <= '0;
        end else if (i_req.valid) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Byte lanes written on the completing edge
    always_ff @(posedge i_clk_ahb) begin
        if (done && i_req.we) begin
            for (int b = 0; b < `AHB_DATA_W / 8; b++) begin
                if (i_req.wstrb[b]) begin
                    mem[i_req.addr][8*b +: 8] <= i_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        o_rsp.ready    = done;
        o_rsp.rd_valid = done && !i_req.we;
        o_rsp.rdata    = mem[i_req.addr];  // Async read of addressed word
    end

    a_ready_needs_valid: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        o_rsp.ready |-> i_req.valid
    );

    // A request dropped before completion would leave the count behind
    a_valid_held: assert property (
        @(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (i_req.valid && !o_rsp.ready) |=> i_req.valid
    );

endmodule

`default_nettype wire

/* tb/tb_ahb_mem.sv */
`timescale 1ns/10ps
`default_nettype none
`include "ahb_mem_consts.svh"

module tb_ahb_mem;
    import ahb_mem_pkg::*;

    localparam int MEM_BYTES = `MEM_WORDS * 4;
    localparam int PHASE_CYC = 1 + `MEM_WAIT;
    localparam int TIMEOUT   = 50;

    typedef struct packed {
        logic                   we;
        hsize_e                 size;
        logic [`AHB_ADDR_W-1:0] addr;
        logic [`AHB_DATA_W-1:0] data;
    } bus_op_t;

    logic                   clk_ahb;
    logic                   rstn_ahb;
    logic                   hsel;
    htrans_e                htrans;
    hsize_e                 hsize;
    logic                   hwrite;
    logic [`AHB_ADDR_W-1:0] haddr;
    logic [`AHB_DATA_W-1:0] hwdata;
    logic                   hready;
    logic                   hreadyout;
    logic                   hresp;
    logic [`AHB_DATA_W-1:0] hrdata;

    logic [7:0] model_mem [MEM_BYTES];  // Reference byte image
    bus_op_t    op_q [$];
    int         data_errs  = 0;
    int         resp_errs  = 0;
    int         cycle_errs = 0;
    int         stall_errs = 0;

    tb_clk_gen clk_gen_i (
        .o_clk  (clk_ahb),
        .o_rstn (rstn_ahb)
    );

    ahb_mem_top dut_i (
        .i_clk_ahb   (clk_ahb),
        .i_rstn_ahb  (rstn_ahb),
        .i_hsel      (hsel),
        .i_htrans    (htrans),
        .i_hsize     (hsize),
        .i_hwrite    (hwrite),
        .i_haddr     (haddr),
        .i_hwdata    (hwdata),
        .i_hready    (hready),
        .o_hreadyout (hreadyout),
        .o_hresp     (hresp),
        .o_hrdata    (hrdata)
    );

    task automatic finish_run();
        $display("Errors: data %0d, resp %0d, cycles %0d, stalls %0d",
                 data_errs, resp_errs, cycle_errs, stall_errs);
        if (data_errs + resp_errs + cycle_errs + stall_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic check_data(string name, logic [`AHB_DATA_W-1:0] got,
                              logic [`AHB_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_resp(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            resp_errs++;
        end
    endtask

    task automatic check_cycles(int got, int exp);
        if (got != exp) begin
            $display("Error: data phase cycles = 0x%0h, expected 0x%0h", got, exp);
            cycle_errs++;
        end
    endtask

    // Lanes touched by a write of this size at this offset
    function automatic logic [3:0] lane_mask(hsize_e size, logic [1:0] off);
        logic [3:0] mask;
        mask = 4'b0000;
        case (size)
            HSIZE_BYTE: mask[off] = 1'b1;
            HSIZE_HALF: begin
                mask[{off[1], 1'b0}] = 1'b1;
                mask[{off[1], 1'b1}] = 1'b1;
            end
            default: mask = 4'b1111;
        endcase
        return mask;
    endfunction

    function automatic void apply_write(bus_op_t op);
        int         base;
        logic [3:0] mask;
        base = int'({op.addr[31:2], 2'b00});
        mask = lane_mask(op.size, op.addr[1:0]);
        for (int lane = 0; lane < 4; lane++) begin
            if (mask[lane]) model_mem[base + lane] = op.data[8*lane +: 8];
        end
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] addr);
        int base;
        base = int'({addr[31:2], 2'b00});
        return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
    endfunction

    // Counts cycles up to and including the one with HREADYOUT high
    task automatic wait_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_ahb);
            cycles++;
        end while (!hreadyout && cycles < TIMEOUT);
        if (!hreadyout) begin
            $display("Bus stalled: HREADYOUT stayed low for %0d cycles", cycles);
            stall_errs++;
            forever @(negedge clk_ahb);  // Held here until the run ends
        end
    endtask

    task automatic drive_addr(bus_op_t op);
        hsel   <= 1'b1;
        htrans <= HTRANS_NONSEQ;
        hsize  <= op.size;
        hwrite <= op.we;
        haddr  <= op.addr;
    endtask

    task automatic drive_idle();
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
    endtask

    // Issues queued ops back to back, next address during current data phase
    task automatic run_ops();
        int      cyc;
        bus_op_t op;
        @(posedge clk_ahb);
        drive_addr(op_q[0]);
        wait_ready(cyc);
        @(posedge clk_ahb);
        for (int k = 0; k < op_q.size(); k++) begin
            op = op_q[k];
            hwdata <= op.we ? op.data : '0;
            if (k + 1 < op_q.size()) drive_addr(op_q[k + 1]);
            else drive_idle();
            wait_ready(cyc);
            check_cycles(cyc, PHASE_CYC);
            check_resp("o_hresp", hresp, 1'b0);
            if (!op.we) check_data("o_hrdata", hrdata, model_word(op.addr));
            @(posedge clk_ahb);
            if (op.we) apply_write(op);
        end
        op_q.delete();
    endtask

    task automatic ahb_write(logic [31:0] addr, logic [31:0] data, hsize_e size);
        op_q.push_back('{we: 1'b1, size: size, addr: addr, data: data});
        run_ops();
    endtask

    task automatic ahb_read(logic [31:0] addr);
        op_q.push_back('{we: 1'b0, size: HSIZE_WORD, addr: addr, data: '0});
        run_ops();
    endtask

    task automatic ahb_pipelined(int pairs);
        logic [31:0] addr;
        for (int k = 0; k < pairs; k++) begin
            addr = $urandom_range(0, `MEM_WORDS - 1) * 4;
            op_q.push_back('{we: 1'b1, size: HSIZE_WORD, addr: addr, data: $urandom()});
            addr = $urandom_range(0, `MEM_WORDS - 1) * 4;
            op_q.push_back('{we: 1'b0, size: HSIZE_WORD, addr: addr, data: '0});
        end
        run_ops();
    endtask

    task automatic reset_state();
        @(negedge clk_ahb);
        check_resp("o_hreadyout", hreadyout, 1'b1);
        check_resp("o_hresp", hresp, 1'b0);
    endtask

    // Every word gets a value derived from its full index
    task automatic fill_memory();
        logic [7:0] w;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            w = i[7:0];
            op_q.push_back('{we: 1'b1, size: HSIZE_WORD, addr: i * 4,
                             data: {w, ~w, w ^ 8'h3c, w ^ 8'h96}});
        end
        run_ops();
    endtask

    task automatic word_write_read();
        logic [31:0] addr;
        repeat (8) begin
            addr = $urandom_range(0, `MEM_WORDS - 1) * 4;
            ahb_write(addr, $urandom(), HSIZE_WORD);
            ahb_read(addr);
        end
    endtask

    task automatic sub_word_writes();
        logic [31:0] base;
        repeat (3) begin
            base = $urandom_range(0, `MEM_WORDS - 1) * 4;
            for (int off = 0; off < 4; off++) begin
                ahb_write(base + off, $urandom(), HSIZE_BYTE);
                ahb_read(base);
            end
            for (int off = 0; off < 4; off += 2) begin
                ahb_write(base + off, $urandom(), HSIZE_HALF);
                ahb_read(base);
            end
        end
    endtask

    task automatic error_response();
        int          cyc;
        bus_op_t     op;
        logic [31:0] bad [3];
        bad = '{32'h0000_0400, 32'h0000_07fc, 32'hffff_fffc};
        for (int k = 0; k < 3; k++) begin
            op = '{we: (k != 1), size: HSIZE_WORD, addr: bad[k], data: '0};
            @(posedge clk_ahb);
            drive_addr(op);
            wait_ready(cyc);
            @(posedge clk_ahb);
            drive_idle();
            hwdata <= $urandom();
            @(negedge clk_ahb);
            check_resp("o_hresp", hresp, 1'b1);
            check_resp("o_hreadyout", hreadyout, 1'b0);
            @(negedge clk_ahb);
            check_resp("o_hresp", hresp, 1'b1);
            check_resp("o_hreadyout", hreadyout, 1'b1);
            @(negedge clk_ahb);
            check_resp("o_hresp", hresp, 1'b0);
        end
        ahb_read(32'h0);   // Aliases of the bad addresses
        ahb_read(32'h3fc);
        ahb_read($urandom_range(0, `MEM_WORDS - 1) * 4);
    endtask

    // HSEL low, IDLE, BUSY, then NONSEQ with HREADY low
    task automatic idle_transfers();
        logic [31:0] base;
        base = $urandom_range(0, `MEM_WORDS - 1) * 4;
        for (int c = 0; c < 4; c++) begin
            @(posedge clk_ahb);
            hsel   <= (c != 0);
            htrans <= (c == 1) ? HTRANS_IDLE : (c == 2) ? HTRANS_BUSY : HTRANS_NONSEQ;
            hready <= (c != 3);
            hwrite <= 1'b1;
            hsize  <= HSIZE_WORD;
            haddr  <= base;
            hwdata <= $urandom();
            repeat (PHASE_CYC + 1) begin
                @(negedge clk_ahb);
                check_resp("o_hreadyout", hreadyout, 1'b1);
                check_resp("o_hresp", hresp, 1'b0);
            end
        end
        @(posedge clk_ahb);
        drive_idle();
        hready <= 1'b1;
        ahb_read(base);
    endtask

    // Ends the run once a wait has timed out
    initial begin
        wait (stall_errs != 0);
        finish_run();
    end

    initial begin
        int cyc;
        void'($urandom(32'h6c19_e4a9));
        hsel   = 1'b0;
        htrans = HTRANS_IDLE;
        hsize  = HSIZE_WORD;
        hwrite = 1'b0;
        haddr  = '0;
        hwdata = '0;
        hready = 1'b1;

        cyc = 0;
        while (!rstn_ahb && cyc < TIMEOUT) begin
            @(negedge clk_ahb);
            cyc++;
        end
        if (!rstn_ahb) begin
            $display("Reset was never released");
            stall_errs++;
        end else begin
            reset_state();
            fill_memory();
            word_write_read();
            sub_word_writes();
            ahb_pipelined(6);
            error_response();
            idle_transfers();
            finish_run();
        end
    end

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_rstn
);
    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Released on a rising edge
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rstn <= 1'b1;
    end

endmodule

`default_nettype wire
